//--- hdl/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

    ////////////////////
    // core widths
    ////////////////////

    // byte address on the fetch side
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] instr_t;

    ////////////////////
    // boot
    ////////////////////

    // first fetch address after reset
    localparam addr_t DEF_RESET_PC = 32'h1c00_0000;

endpackage

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    // valid bits of a fetched pair
    // bit 1 is slot 1 (older), bit 0 is slot 2
    typedef logic [1:0] slot_mask_t;

    // word index in a 16-byte line, taken from pc[3:2]
    // the last word has no second slot in the same line
    localparam logic [1:0] LINE_LAST_WORD = 2'd3;

    // pc increments in bytes
    localparam int unsigned PAIR_STEP   = 8; // two words per cycle
    localparam int unsigned SINGLE_STEP = 4; // one word, end of line

endpackage

//--- hdl/fetch_pair_if.sv
`timescale 1ns/1ps

// one fetched pair between the if2 stage and the instruction buffer
interface fetch_pair_if
    import cpu_cfg_pkg::*;
    import fetch_pkg::*;
();

    addr_t      pc1;   // slot 2 sits at pc1 + 4
    instr_t     ir1;
    instr_t     ir2;
    slot_mask_t valid; // nonzero means a pair is offered

    modport src (
        output pc1,
        output ir1,
        output ir2,
        output valid
    );

    modport dst (
        input pc1,
        input ir1,
        input ir2,
        input valid
    );

endinterface

//--- hdl/pc_gen.sv
`timescale 1ns/1ps

module pc_gen
    import cpu_cfg_pkg::*;
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = DEF_RESET_PC
) (
    input  logic  clk,
    input  logic  i_arst_n,
    input  logic  i_br,
    input  addr_t i_br_pc,
    input  logic  i_hold,
    output addr_t o_pc,
    output logic  o_req
);

    addr_t pc;      // next address to request
    addr_t pc_last; // address of the pair now waiting in if2
    addr_t pc_step;
    logic  req;

    // only one word left in the line
    assign pc_step = (pc[3:2] == LINE_LAST_WORD) ? addr_t'(SINGLE_STEP) : addr_t'(PAIR_STEP);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= RESET_PC;
            pc_last <= RESET_PC;
            req     <= 1'b0;
        end else begin
            req <= 1'b1; // fetch starts right after reset
            if (i_br) begin
                pc      <= i_br_pc; // redirect beats any stall
                pc_last <= i_br_pc;
            end else if (req && !i_hold) begin
                pc      <= pc + pc_step;
                pc_last <= pc;
            end
        end
    end

    // while held, keep asking for the stalled pair so the memory
    // returns its words again in the next cycle
    assign o_pc  = i_hold ? pc_last : pc;
    assign o_req = req;

    ////////////////////
    // checks
    ////////////////////

    assert property (@(posedge clk) disable iff (!i_arst_n) o_pc[1:0] == 2'b00)
        else $error("ERR pc_gen o_pc misaligned %h", o_pc);

endmodule

//--- hdl/if1_if2_reg.sv
`timescale 1ns/1ps

module if1_if2_reg
    import cpu_cfg_pkg::*;
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,
    input  addr_t     i_pc,
    input  logic      i_req,
    input  logic      i_imem_ready,
    input  instr_t    i_imem_ir1,
    input  instr_t    i_imem_ir2,
    input  logic      i_flush,
    input  logic      i_buf_full,
    output logic      o_hold,
    fetch_pair_if.src pair
);

    addr_t      pc_r;    // address whose words arrive this cycle
    slot_mask_t valid_r;
    slot_mask_t pc_mask;

    // the one place the fetch stall is formed
    assign o_hold = !i_imem_ready || i_buf_full;

    // no second slot on the last word of a line
    assign pc_mask = {1'b1, i_pc[3:2] != LINE_LAST_WORD};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_r <= '0;
        end else if (i_flush) begin
            valid_r <= '0; // wrong-path pair
        end else if (!o_hold) begin
            valid_r <= i_req ? pc_mask : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!o_hold) begin
            pc_r <= i_pc;
        end
    end

    // words come straight from memory, paired with the stored pc
    assign pair.pc1   = pc_r;
    assign pair.ir1   = i_imem_ir1;
    assign pair.ir2   = i_imem_ir2;
    assign pair.valid = (i_imem_ready && !i_flush) ? valid_r : '0; // nothing until memory is ready

endmodule

//--- hdl/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer
    import cpu_cfg_pkg::*;
    import fetch_pkg::*;
#(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic       clk,
    input  logic       i_arst_n,
    fetch_pair_if.dst  pair,
    input  logic       i_flush,
    input  logic       i_pop_stall,
    output logic       o_full,
    output addr_t      o_pc1,
    output addr_t      o_pc2,
    output instr_t     o_ir1,
    output instr_t     o_ir2,
    output slot_mask_t o_valid
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);

    ////////////////////
    // storage
    ////////////////////

    addr_t      pc_q   [BUF_DEPTH];
    instr_t     ir1_q  [BUF_DEPTH];
    instr_t     ir2_q  [BUF_DEPTH];
    slot_mask_t mask_q [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count; // one extra bit to tell full from empty
    logic             empty;
    logic             push;
    logic             pop;

    assign empty  = (count == '0);
    assign o_full = (count == (PTR_W + 1)'(BUF_DEPTH));
    assign push   = (pair.valid != '0) && !o_full && !i_flush;
    assign pop    = !empty && !i_pop_stall && !i_flush;

    ////////////////////
    // pointers
    ////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0; // drop everything on redirect
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_q[wr_ptr]   <= pair.pc1;
            ir1_q[wr_ptr]  <= pair.ir1;
            ir2_q[wr_ptr]  <= pair.ir2;
            mask_q[wr_ptr] <= pair.valid;
        end
    end

    // head of queue to decode
    assign o_pc1   = pc_q[rd_ptr];
    assign o_pc2   = pc_q[rd_ptr] + addr_t'(SINGLE_STEP);
    assign o_ir1   = ir1_q[rd_ptr];
    assign o_ir2   = ir2_q[rd_ptr];
    assign o_valid = empty ? '0 : mask_q[rd_ptr];

    // a pair refused while full must still be offered next cycle
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (pair.valid != '0 && o_full && !i_flush) |=> (i_flush || pair.pc1 == $past(pair.pc1)))
        else $error("ERR instr_buffer pair.pc1 %h dropped while full", $past(pair.pc1));

    // stalled head stays put
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (!empty && i_pop_stall && !i_flush) |=>
            (o_valid == $past(o_valid) && o_pc1 == $past(o_pc1)))
        else $error("ERR instr_buffer o_pc1 %h changed under stall", o_pc1);

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import cpu_cfg_pkg::*;
    import fetch_pkg::*;
#(
    parameter addr_t       RESET_PC  = DEF_RESET_PC,
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_br,
    input  addr_t      i_br_pc,
    input  logic       i_imem_ready,
    input  instr_t     i_imem_ir1,
    input  instr_t     i_imem_ir2,
    input  logic       i_issue_stall,
    output addr_t      o_imem_addr,
    output logic       o_imem_req,
    output addr_t      o_id_pc1,
    output addr_t      o_id_pc2,
    output instr_t     o_id_ir1,
    output instr_t     o_id_ir2,
    output slot_mask_t o_id_valid
);

    logic hold;     // memory not ready or buffer full
    logic buf_full;

    fetch_pair_if pair_if ();

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) i_pc_gen (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_br     (i_br),
        .i_br_pc  (i_br_pc),
        .i_hold   (hold),
        .o_pc     (o_imem_addr),
        .o_req    (o_imem_req)
    );

    if1_if2_reg i_if1_if2_reg (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_pc         (o_imem_addr),
        .i_req        (o_imem_req),
        .i_imem_ready (i_imem_ready),
        .i_imem_ir1   (i_imem_ir1),
        .i_imem_ir2   (i_imem_ir2),
        .i_flush      (i_br),
        .i_buf_full   (buf_full),
        .o_hold       (hold),
        .pair         (pair_if.src)
    );

    instr_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_instr_buffer (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .pair        (pair_if.dst),
        .i_flush     (i_br),
        .i_pop_stall (i_issue_stall),
        .o_full      (buf_full),
        .o_pc1       (o_id_pc1),
        .o_pc2       (o_id_pc2),
        .o_ir1       (o_id_ir1),
        .o_ir2       (o_id_ir2),
        .o_valid     (o_id_valid)
    );

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
    import cpu_cfg_pkg::*;
    import fetch_pkg::*;
();

    localparam addr_t       RESET_PC  = 32'h1c00_0000;
    localparam int unsigned BUF_DEPTH = 4;
    localparam instr_t      MEM_KEY   = 32'ha5a5_0000; // word = address ^ key

    // run length per test sets the timeout
    localparam int RESET_CYC   = 8;
    localparam int SEQ_POPS    = 96;
    localparam int BR_COUNT    = 6;
    localparam int BR_POPS     = 8;
    localparam int FULL_HOLD   = 32;
    localparam int FULL_POPS   = 16;
    localparam int CYC_PER_POP = 12; // room for random not-ready and stall cycles
    localparam int TIMEOUT_CYC = RESET_CYC + FULL_HOLD
                                 + (SEQ_POPS + BR_COUNT * BR_POPS + FULL_POPS) * CYC_PER_POP;

    logic       clk;
    logic       i_arst_n;
    logic       i_br;
    addr_t      i_br_pc;
    logic       i_imem_ready;
    instr_t     i_imem_ir1;
    instr_t     i_imem_ir2;
    logic       i_issue_stall;
    addr_t      o_imem_addr;
    logic       o_imem_req;
    addr_t      o_id_pc1;
    addr_t      o_id_pc2;
    instr_t     o_id_ir1;
    instr_t     o_id_ir2;
    slot_mask_t o_id_valid;

    integer seed;
    addr_t  mem_addr;   // request of the previous cycle
    addr_t  exp_pc;     // pc1 the next popped pair must carry
    logic   pop;
    int     pops = 0;
    int     cycles = 0;
    int     err_count = 0;
    int     test_count = 0;
    int     test_start_err = 0;

    fetch_top #(
        .RESET_PC  (RESET_PC),
        .BUF_DEPTH (BUF_DEPTH)
    ) i_fetch_top (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_br          (i_br),
        .i_br_pc       (i_br_pc),
        .i_imem_ready  (i_imem_ready),
        .i_imem_ir1    (i_imem_ir1),
        .i_imem_ir2    (i_imem_ir2),
        .i_issue_stall (i_issue_stall),
        .o_imem_addr   (o_imem_addr),
        .o_imem_req    (o_imem_req),
        .o_id_pc1      (o_id_pc1),
        .o_id_pc2      (o_id_pc2),
        .o_id_ir1      (o_id_ir1),
        .o_id_ir2      (o_id_ir2),
        .o_id_valid    (o_id_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // instruction memory
    ////////////////////

    always @(posedge clk) begin
        mem_addr <= o_imem_addr;
    end

    always @(negedge clk) begin
        i_imem_ir1 <= mem_addr ^ MEM_KEY;
        i_imem_ir2 <= (mem_addr + 32'd4) ^ MEM_KEY; // next word
    end

    ////////////////////
    // reference pc
    ////////////////////

    assign pop = i_arst_n && (o_id_valid != '0) && !i_issue_stall && !i_br;

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            exp_pc <= RESET_PC;
        end else if (i_br) begin
            exp_pc <= i_br_pc; // old path is dropped
        end else if (pop) begin
            exp_pc <= exp_pc + ((exp_pc[3:2] == 2'd3) ? 32'd4 : 32'd8);
            pops   <= pops + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= TIMEOUT_CYC);
        $display("timeout after %0d cycles with %0d pairs popped", cycles, pops);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////
    // checks
    ////////////////////

    assert property (@(posedge clk) !i_arst_n |-> (o_id_valid == '0 && !o_imem_req))
        else begin
            err_count++;
            $display("ERR o_id_valid %h o_imem_req %h in reset",
                     $sampled(o_id_valid), $sampled(o_imem_req));
        end

    // first cycle out of reset
    assert property (@(posedge clk) $rose(i_arst_n) |-> ##1 (o_imem_req && o_id_valid == '0))
        else begin
            err_count++;
            $display("ERR o_imem_req %h o_id_valid %h after reset",
                     $sampled(o_imem_req), $sampled(o_id_valid));
        end

    // a stalled fetch keeps asking for the same address
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (!i_imem_ready && !$past(i_br)) |-> o_imem_addr == $past(o_imem_addr))
        else begin
            err_count++;
            $display("ERR o_imem_addr %h expected %h while not ready",
                     $sampled(o_imem_addr), $past(o_imem_addr));
        end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        o_id_valid[1] |-> o_id_ir1 == (o_id_pc1 ^ MEM_KEY))
        else begin
            err_count++;
            $display("ERR o_id_ir1 %h expected %h",
                     $sampled(o_id_ir1), $sampled(o_id_pc1) ^ MEM_KEY);
        end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        o_id_valid[0] |-> o_id_ir2 == ((o_id_pc1 + 32'd4) ^ MEM_KEY))
        else begin
            err_count++;
            $display("ERR o_id_ir2 %h expected %h",
                     $sampled(o_id_ir2), ($sampled(o_id_pc1) + 32'd4) ^ MEM_KEY);
        end

    // slot 2 only when the line has a word left
    assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_id_valid != '0) |-> o_id_valid == {1'b1, o_id_pc1[3:2] != 2'd3})
        else begin
            err_count++;
            $display("ERR o_id_valid %h for o_id_pc1 %h",
                     $sampled(o_id_valid), $sampled(o_id_pc1));
        end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        o_id_valid[0] |-> o_id_pc2 == exp_pc + 32'd4)
        else begin
            err_count++;
            $display("ERR o_id_pc2 %h expected %h",
                     $sampled(o_id_pc2), $sampled(exp_pc) + 32'd4);
        end

    assert property (@(posedge clk) disable iff (!i_arst_n) pop |-> o_id_pc1 == exp_pc)
        else begin
            err_count++;
            $display("ERR o_id_pc1 %h expected %h", $sampled(o_id_pc1), $sampled(exp_pc));
        end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_id_valid != '0 && i_issue_stall && !i_br) |=>
            (o_id_valid == $past(o_id_valid) && o_id_pc1 == $past(o_id_pc1)
             && o_id_ir1 == $past(o_id_ir1) && o_id_ir2 == $past(o_id_ir2)))
        else begin
            err_count++;
            $display("ERR o_id_pc1 %h was %h under issue stall",
                     $sampled(o_id_pc1), $past(o_id_pc1));
        end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic wait_pops(input int n, input logic use_random);
        int target;
        target = pops + n;
        while (pops < target) begin
            @(negedge clk);
            if (use_random) begin
                i_imem_ready  = ($random(seed) & 3) != 0; // ready 3 of 4
                i_issue_stall = ($random(seed) & 3) == 0; // stall 1 of 4
            end
        end
    endtask

    task automatic redirect(input addr_t target);
        @(negedge clk);
        i_br    = 1'b1;
        i_br_pc = target;
        @(negedge clk);
        i_br    = 1'b0;
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %-9s done, %0d errors", name, err_count - test_start_err);
        test_start_err = err_count;
    endtask

    initial begin
        seed          = 32'h83287805;
        i_arst_n      = 1'b0;
        i_br          = 1'b0;
        i_br_pc       = '0;
        i_imem_ready  = 1'b0;
        i_imem_ir1    = '0;
        i_imem_ir2    = '0;
        i_issue_stall = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        i_arst_n     = 1'b1;
        i_imem_ready = 1'b1;
        wait_pops(1, 1'b0); // first pair must come from RESET_PC
        report_test("reset");

        wait_pops(SEQ_POPS, 1'b1);
        report_test("sequence");

        for (int i = 0; i < BR_COUNT; i++) begin
            if (i == 0) begin
                redirect(32'h8000_000c); // last word of a line
            end else begin
                redirect(addr_t'($random(seed)) & 32'hffff_fffc);
            end
            wait_pops(BR_POPS, 1'b1);
        end
        report_test("branch");

        // decode held long enough to fill the buffer
        @(negedge clk);
        i_imem_ready  = 1'b1;
        i_issue_stall = 1'b1;
        repeat (FULL_HOLD) @(negedge clk);
        i_issue_stall = 1'b0;
        wait_pops(FULL_POPS, 1'b0);
        report_test("full");

        $display("tests %0d, pairs popped %0d, errors %0d", test_count, pops, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/cpu_cfg_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_pair_if.sv
hdl/pc_gen.sv
hdl/if1_if2_reg.sv
hdl/instr_buffer.sv
hdl/fetch_top.sv
dv/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_front

sources:
  - hdl/cpu_cfg_pkg.sv
  - hdl/fetch_pkg.sv
  - hdl/fetch_pair_if.sv
  - hdl/pc_gen.sv
  - hdl/if1_if2_reg.sv
  - hdl/instr_buffer.sv
  - hdl/fetch_top.sv
  - target: simulation
    files:
      - dv/fetch_tb.sv
